//--- sources.f
hw/merge_pkg.sv
hw/stream_fifo.sv
hw/stream_serialize.sv
hw/stream_merge_top.sv
test/tb_stream_merge.sv

//--- Bender.yml
package:
  name: stream_merge

sources:
  # design
  - files:
      - hw/merge_pkg.sv
      - hw/stream_fifo.sv
      - hw/stream_serialize.sv
      - hw/stream_merge_top.sv
  # testbench
  - target: test
    files:
      - test/tb_stream_merge.sv

//--- test/merge_testdata.txt
# T idx nb_contig_m1 first_stream backpressure serdes_clear late_stream late_delay
# B data0 strb0 data1 strb1 data2 strb2 data3 strb3   (one beat per stream, hex)
# E id data strb (x4)   expected output beats in order, hex

# single beat turns, ids alternate 0 1 2 3
T 1 0 0 0 0 0 0
B 10000001 f 20000001 3 30000001 c 40000001 1
B 10000002 e 20000002 7 30000002 8 40000002 f
B 10000003 5 20000003 a 30000003 6 40000003 0
E 0 10000001 f 1 20000001 3 2 30000001 c 3 40000001 1
E 0 10000002 e 1 20000002 7 2 30000002 8 3 40000002 f
E 0 10000003 5 1 20000003 a 2 30000003 6 3 40000003 0

# runs of three beats per stream
T 2 2 0 0 0 0 0
B 11110000 f 22220000 f 33330000 f 44440000 f
B 11110001 1 22220001 2 33330001 4 44440001 8
B 11110002 3 22220002 6 33330002 c 44440002 9
E 0 11110000 f 0 11110001 1 0 11110002 3 1 22220000 f
E 1 22220001 2 1 22220002 6 2 33330000 f 2 33330001 4
E 2 33330002 c 3 44440000 f 3 44440001 8 3 44440002 9

# rotation restarted at stream 2
T 3 0 2 0 1 0 0
B a0000000 f b0000000 1 c0000000 2 d0000000 4
B a0000001 8 b0000001 f c0000001 5 d0000001 a
E 2 c0000000 2 3 d0000000 4 0 a0000000 f 1 b0000000 1
E 2 c0000001 5 3 d0000001 a 0 a0000001 8 1 b0000001 f

# same data as test 1 under random back-pressure, starts at id 0 after clear
T 4 0 0 1 0 0 0
B 10000001 f 20000001 3 30000001 c 40000001 1
B 10000002 e 20000002 7 30000002 8 40000002 f
B 10000003 5 20000003 a 30000003 6 40000003 0
E 0 10000001 f 1 20000001 3 2 30000001 c 3 40000001 1
E 0 10000002 e 1 20000002 7 2 30000002 8 3 40000002 f
E 0 10000003 5 1 20000003 a 2 30000003 6 3 40000003 0

# stream 1 starts 30 cycles late, merge waits for it
T 5 0 0 0 0 1 30
B 50000000 1 60000000 2 70000000 4 80000000 8
B 50000001 3 60000001 6 70000001 c 80000001 9
E 0 50000000 1 1 60000000 2 2 70000000 4 3 80000000 8
E 0 50000001 3 1 60000001 6 2 70000001 c 3 80000001 9

# pairs from stream 1 onward with back-pressure
T 6 1 1 1 1 0 0
B 91000000 f 92000001 3 93000002 c 94000003 f
B 91000010 1 92000011 2 93000012 4 94000013 8
E 1 92000001 3 1 92000011 2 2 93000002 c 2 93000012 4
E 3 94000003 f 3 94000013 8 0 91000000 f 0 91000010 1

//--- test/tb_stream_merge.sv
`timescale 1ns/1ns

module tb_stream_merge;

  localparam int MAX_TESTS  = 8;
  localparam int MAX_BEATS  = 8;
  localparam int NB_STREAMS = merge_pkg::NB_IN_STREAMS;
  // cycles without an output transfer before a test gives up
  localparam int IDLE_LIMIT = 100;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic clear_i;
  logic clear_serdes_state_i;
  logic [merge_pkg::STREAM_ID_WIDTH-1:0] first_stream_i;
  logic [merge_pkg::CONTIG_WIDTH-1:0]    nb_contig_m1_i;
  logic [NB_STREAMS-1:0]                 push_valid_i;
  logic [NB_STREAMS-1:0]                 push_ready_o;
  merge_pkg::stream_beat_t [NB_STREAMS-1:0] push_data_i;
  logic                    pop_valid_o;
  logic                    pop_ready_i;
  merge_pkg::tagged_beat_t pop_data_o;

  // per-test configuration from the data file
  int cfg_idx    [MAX_TESTS];
  int cfg_bp     [MAX_TESTS];
  int cfg_serdes [MAX_TESTS];
  int cfg_late   [MAX_TESTS];
  int cfg_delay  [MAX_TESTS];
  int nb_in      [MAX_TESTS];
  int nb_exp     [MAX_TESTS];
  logic [merge_pkg::CONTIG_WIDTH-1:0]    cfg_contig [MAX_TESTS];
  logic [merge_pkg::STREAM_ID_WIDTH-1:0] cfg_first  [MAX_TESTS];
  // input beats per stream and the expected tagged output order
  merge_pkg::stream_beat_t in_beat  [MAX_TESTS][NB_STREAMS][MAX_BEATS];
  merge_pkg::tagged_beat_t exp_beat [MAX_TESTS][NB_STREAMS*MAX_BEATS];

  int nt = 0;
  int cur_test;
  int t;
  int err_cnt = 0;
  int chk_cnt = 0;
  int cycle_cnt = 0;
  int cycle_limit = 200;
  integer seed = 32'hfb9a_962d;

  stream_merge_top dut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .clear_i              (clear_i),
    .clear_serdes_state_i (clear_serdes_state_i),
    .first_stream_i       (first_stream_i),
    .nb_contig_m1_i       (nb_contig_m1_i),
    .push_valid_i         (push_valid_i),
    .push_ready_o         (push_ready_o),
    .push_data_i          (push_data_i),
    .pop_valid_o          (pop_valid_o),
    .pop_ready_i          (pop_ready_i),
    .pop_data_o           (pop_data_o)
  );

  always #5 clk_i = ~clk_i;

  // run limit of 40 cycles per expected beat plus a fixed margin
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the merge stopped producing beats", cycle_cnt);
      err_cnt++;
      $display("tests: %0d, checks: %0d, errors: %0d", nt, chk_cnt, err_cnt);
      $display("sim failed");
      $finish;
    end
  end

  // ==============================
  // helpers
  // ==============================

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    chk_cnt++;
    if (expected !== actual) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      err_cnt++;
    end
  endtask

  // data file holds T, B and E lines and # comment lines
  task automatic load_testdata();
    integer fd;
    int ne;
    logic [8*128-1:0] line;
    logic [8*4-1:0]   tag;
    logic [31:0] d0, d1, d2, d3;
    logic [3:0]  s0, s1, s2, s3;
    logic [merge_pkg::STREAM_ID_WIDTH-1:0] i0, i1, i2, i3;
    fd = $fopen("test/merge_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/merge_testdata.txt");
      err_cnt++;
      return;
    end
    line = '0;
    while ($fgets(line, fd) != 0) begin
      tag = '0;
      void'($sscanf(line, "%s", tag));
      if (tag == "T" && nt < MAX_TESTS) begin
        // test header opens a new section
        void'($sscanf(line, "%s %d %d %d %d %d %d %d", tag, cfg_idx[nt], cfg_contig[nt],
                      cfg_first[nt], cfg_bp[nt], cfg_serdes[nt], cfg_late[nt], cfg_delay[nt]));
        nb_in[nt]  = 0;
        nb_exp[nt] = 0;
        nt++;
      end else if (tag == "B" && nt > 0 && nb_in[nt-1] < MAX_BEATS) begin
        // one beat for each of the four streams
        void'($sscanf(line, "%s %h %h %h %h %h %h %h %h", tag, d0, s0, d1, s1, d2, s2, d3, s3));
        in_beat[nt-1][0][nb_in[nt-1]] = {d0, s0};
        in_beat[nt-1][1][nb_in[nt-1]] = {d1, s1};
        in_beat[nt-1][2][nb_in[nt-1]] = {d2, s2};
        in_beat[nt-1][3][nb_in[nt-1]] = {d3, s3};
        nb_in[nt-1]++;
      end else if (tag == "E" && nt > 0 && nb_exp[nt-1] < NB_STREAMS*MAX_BEATS) begin
        // four expected beats per line
        void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", tag,
                      i0, d0, s0, i1, d1, s1, i2, d2, s2, i3, d3, s3));
        ne = nb_exp[nt-1];
        exp_beat[nt-1][ne]   = {i0, d0, s0};
        exp_beat[nt-1][ne+1] = {i1, d1, s1};
        exp_beat[nt-1][ne+2] = {i2, d2, s2};
        exp_beat[nt-1][ne+3] = {i3, d3, s3};
        nb_exp[nt-1] = ne + 4;
        cycle_limit += 160;
      end
      line = '0;
    end
    $fclose(fd);
  endtask

  // ==============================
  // stimulus and monitor
  // ==============================

  // presents one stream's beats in order and holds each until accepted
  task automatic drive_stream(input int s);
    int b;
    if (s == cfg_late[cur_test]) begin
      repeat (cfg_delay[cur_test]) begin
        @(posedge clk_i);
        #1;
      end
    end
    for (b = 0; b < nb_in[cur_test]; b++) begin
      push_valid_i[s] = 1'b1;
      push_data_i[s]  = in_beat[cur_test][s][b];
      @(posedge clk_i);
      // ready seen at the edge decides the transfer
      while (!push_ready_o[s]) @(posedge clk_i);
      #1;
    end
    push_valid_i[s] = 1'b0;
  endtask

  // compares every output transfer with the next expected beat
  task automatic watch_output();
    int n;
    int idle;
    int rnd;
    n    = 0;
    idle = 0;
    while (n < nb_exp[cur_test] && idle < IDLE_LIMIT) begin
      if (cfg_bp[cur_test] != 0) begin
        rnd = $random(seed);
        pop_ready_i = rnd[0];
      end else begin
        pop_ready_i = 1'b1;
      end
      @(posedge clk_i);
      if (pop_valid_o && pop_ready_i) begin
        check_value($sformatf("test%0d beat%0d", cfg_idx[cur_test], n),
                    exp_beat[cur_test][n], pop_data_o);
        n++;
        idle = 0;
      end else begin
        idle++;
      end
      #1;
    end
    pop_ready_i = 1'b0;
    if (n < nb_exp[cur_test]) begin
      $display("test%0d: only %0d of %0d output beats arrived", cfg_idx[cur_test], n,
               nb_exp[cur_test]);
      err_cnt++;
    end
  endtask

  task automatic run_test(input int tn);
    int k;
    int extra;
    cur_test       = tn;
    nb_contig_m1_i = cfg_contig[tn];
    first_stream_i = cfg_first[tn];
    // soft clear empties all fifos and restarts selection at stream 0
    clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    clear_i = 1'b0;
    if (cfg_serdes[tn] != 0) begin
      // one-cycle pulse reloads the rotation from first_stream_i
      clear_serdes_state_i = 1'b1;
      @(posedge clk_i);
      #1;
      clear_serdes_state_i = 1'b0;
    end
    fork
      drive_stream(0);
      drive_stream(1);
      drive_stream(2);
      drive_stream(3);
      watch_output();
    join
    // nothing may follow the expected sequence
    extra       = 0;
    pop_ready_i = 1'b1;
    for (k = 0; k < 8; k++) begin
      @(posedge clk_i);
      if (pop_valid_o) extra++;
      #1;
    end
    pop_ready_i = 1'b0;
    if (extra != 0) begin
      $display("test%0d: %0d extra output beats after the expected ones", cfg_idx[tn], extra);
      err_cnt++;
    end
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin
    rst_ni               = 1'b0;
    clear_i              = 1'b0;
    clear_serdes_state_i = 1'b0;
    first_stream_i       = '0;
    nb_contig_m1_i       = '0;
    push_valid_i         = '0;
    push_data_i          = '0;
    pop_ready_i          = 1'b0;
    load_testdata();
    if (nt == 0) begin
      $display("no test sections found in the data file");
      err_cnt++;
    end
    repeat (5) @(posedge clk_i);
    #1;
    // fifos leave reset empty, so inputs ready and output idle
    check_value("reset pop_valid", 64'd0, pop_valid_o);
    check_value("reset push_ready", {NB_STREAMS{1'b1}}, push_ready_o);
    rst_ni = 1'b1;
    for (t = 0; t < nt; t++) begin
      run_test(t);
    end
    $display("tests: %0d, checks: %0d, errors: %0d", nt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- hw/stream_merge_top.sv
`timescale 1ns/1ns

// stream merger
// four buffered inputs, round-robin serializer, buffered tagged output
module stream_merge_top (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,

  // serializer control
  input  logic                                  clear_serdes_state_i,
  input  logic [merge_pkg::STREAM_ID_WIDTH-1:0] first_stream_i,
  input  logic [merge_pkg::CONTIG_WIDTH-1:0]    nb_contig_m1_i,

  // input streams
  input  logic [merge_pkg::NB_IN_STREAMS-1:0]                    push_valid_i,
  output logic [merge_pkg::NB_IN_STREAMS-1:0]                    push_ready_o,
  input  merge_pkg::stream_beat_t [merge_pkg::NB_IN_STREAMS-1:0] push_data_i,

  // merged output stream
  output logic                    pop_valid_o,
  input  logic                    pop_ready_i,
  output merge_pkg::tagged_beat_t pop_data_o
);

  // input fifo pop sides into the serializer
  logic [merge_pkg::NB_IN_STREAMS-1:0]                    fifo_valid;
  logic [merge_pkg::NB_IN_STREAMS-1:0]                    fifo_ready;
  merge_pkg::stream_beat_t [merge_pkg::NB_IN_STREAMS-1:0] fifo_data;

  // serializer output into the output fifo
  logic                    ser_valid;
  logic                    ser_ready;
  merge_pkg::tagged_beat_t ser_data;

  // ==============================
  // input buffering
  // ==============================

  // one fifo per stream, so idle streams keep accepting beats
  for (genvar k = 0; k < merge_pkg::NB_IN_STREAMS; k++) begin : gen_in_fifo
    stream_fifo #(
      .payload_t (merge_pkg::stream_beat_t)
    ) in_fifo (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .clear_i      (clear_i),
      .push_valid_i (push_valid_i[k]),
      .push_ready_o (push_ready_o[k]),
      .push_data_i  (push_data_i[k]),
      .pop_valid_o  (fifo_valid[k]),
      .pop_ready_i  (fifo_ready[k]),
      .pop_data_o   (fifo_data[k])
    );
  end

  // ==============================
  // serialization
  // ==============================

  stream_serialize serializer (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .clear_i              (clear_i),
    .clear_serdes_state_i (clear_serdes_state_i),
    .first_stream_i       (first_stream_i),
    .nb_contig_m1_i       (nb_contig_m1_i),
    .push_valid_i         (fifo_valid),
    .push_ready_o         (fifo_ready),
    .push_data_i          (fifo_data),
    .pop_valid_o          (ser_valid),
    .pop_ready_i          (ser_ready),
    .pop_data_o           (ser_data)
  );

  // ==============================
  // output buffering
  // ==============================

  // tagged beats, decouples the output port from arbitration
  stream_fifo #(
    .payload_t (merge_pkg::tagged_beat_t)
  ) out_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .push_valid_i (ser_valid),
    .push_ready_o (ser_ready),
    .push_data_i  (ser_data),
    .pop_valid_o  (pop_valid_o),
    .pop_ready_i  (pop_ready_i),
    .pop_data_o   (pop_data_o)
  );

endmodule

//--- hw/stream_serialize.sv
`timescale 1ns/1ns

// round-robin serializer
// takes nb_contig_m1_i+1 beats from one stream, then moves to the next
// each output beat is tagged with its source stream index
module stream_serialize (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,

  // rotation control
  input  logic                                  clear_serdes_state_i,
  input  logic [merge_pkg::STREAM_ID_WIDTH-1:0] first_stream_i,
  input  logic [merge_pkg::CONTIG_WIDTH-1:0]    nb_contig_m1_i,

  // input streams
  input  logic [merge_pkg::NB_IN_STREAMS-1:0]                          push_valid_i,
  output logic [merge_pkg::NB_IN_STREAMS-1:0]                          push_ready_o,
  input  merge_pkg::stream_beat_t [merge_pkg::NB_IN_STREAMS-1:0]       push_data_i,

  // tagged output stream
  output logic                    pop_valid_o,
  input  logic                    pop_ready_i,
  output merge_pkg::tagged_beat_t pop_data_o
);

  // selected stream and beats taken from it so far
  logic [merge_pkg::STREAM_ID_WIDTH-1:0] stream_cnt_d;
  logic [merge_pkg::STREAM_ID_WIDTH-1:0] stream_cnt_q;
  logic [merge_pkg::CONTIG_WIDTH-1:0]    contig_cnt_d;
  logic [merge_pkg::CONTIG_WIDTH-1:0]    contig_cnt_q;

  // output handshake completes
  logic pop_fire;
  // current beat closes this stream's turn
  logic last_contig;

  // ==============================
  // datapath, purely combinational
  // ==============================

  // valid and payload come straight from the selected stream
  assign pop_valid_o = push_valid_i[stream_cnt_q];

  always_comb begin
    pop_data_o.id   = stream_cnt_q;
    pop_data_o.data = push_data_i[stream_cnt_q].data;
    pop_data_o.strb = push_data_i[stream_cnt_q].strb;
  end

  // only the selected stream sees the output ready
  // others are held off, so no stream is ever skipped to
  always_comb begin
    push_ready_o               = '0;
    push_ready_o[stream_cnt_q] = pop_ready_i;
  end

  assign pop_fire = pop_valid_o & pop_ready_i;

  // ==============================
  // next-state logic
  // ==============================

  // >= also closes the turn if the limit is lowered mid-run
  assign last_contig = (contig_cnt_q >= nb_contig_m1_i);

  always_comb begin
    stream_cnt_d = stream_cnt_q;
    contig_cnt_d = contig_cnt_q;
    if (clear_serdes_state_i) begin
      // restart rotation, independent of any transfer
      stream_cnt_d = first_stream_i;
      contig_cnt_d = '0;
    end else if (pop_fire) begin
      if (last_contig) begin
        contig_cnt_d = '0;
        // advance to next stream, wrap after the last one
        if (stream_cnt_q == merge_pkg::LAST_STREAM) begin
          stream_cnt_d = '0;
        end else begin
          stream_cnt_d = stream_cnt_q + 1'b1;
        end
      end else begin
        contig_cnt_d = contig_cnt_q + 1'b1;
      end
    end
  end

  // ==============================
  // state registers
  // ==============================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stream_cnt_q <= '0;
      contig_cnt_q <= '0;
    end else if (clear_i) begin
      // soft clear wins over serdes-state clear
      stream_cnt_q <= '0;
      contig_cnt_q <= '0;
    end else begin
      stream_cnt_q <= stream_cnt_d;
      contig_cnt_q <= contig_cnt_d;
    end
  end

endmodule

//--- hw/stream_fifo.sv
`timescale 1ns/1ns

// valid/ready fifo, circular buffer without bypass
// payload type is chosen per instance
module stream_fifo #(
  parameter type payload_t = merge_pkg::stream_beat_t
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,

  // push side
  input  logic     push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,

  // pop side
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output payload_t pop_data_o
);

  // storage, contents survive reset and clear
  payload_t mem_q [merge_pkg::FIFO_DEPTH];

  logic [merge_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr_q;
  logic [merge_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr_q;
  logic [merge_pkg::FIFO_CNT_WIDTH-1:0] cnt_q;

  logic full;
  logic empty;
  logic push_en;
  logic pop_en;

  // ==============================
  // status and handshake
  // ==============================

  assign full  = (cnt_q == merge_pkg::FIFO_FULL_CNT);
  assign empty = (cnt_q == '0);

  // when full, a push only fits alongside a pop
  // pop needs a non-empty fifo, which full implies
  assign push_ready_o = ~full | pop_ready_i;
  assign pop_valid_o  = ~empty;

  // head of queue, registered storage so no bypass path
  assign pop_data_o = mem_q[rd_ptr_q];

  assign push_en = push_valid_i & push_ready_o;
  assign pop_en  = pop_valid_o & pop_ready_i;

  // ==============================
  // pointers and occupancy
  // ==============================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      // empty the queue, stored words left as they are
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_en) begin
        // wrap at the last entry
        wr_ptr_q <= (wr_ptr_q == merge_pkg::FIFO_LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == merge_pkg::FIFO_LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keep the count
      case ({push_en, pop_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // ==============================
  // storage write
  // ==============================

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

//--- hw/merge_pkg.sv
package merge_pkg;

  // ==============================
  // stream geometry
  // ==============================

  // number of merged input streams
  localparam int unsigned NB_IN_STREAMS = 4;
  // data word width and one strobe bit per byte
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
  // width of a stream index carried as output tag
  localparam int unsigned STREAM_ID_WIDTH = $clog2(NB_IN_STREAMS);
  // index of the last stream, wrap point of the rotation
  localparam logic [STREAM_ID_WIDTH-1:0] LAST_STREAM = STREAM_ID_WIDTH'(NB_IN_STREAMS - 1);
  // contiguous counter width, up to 256 beats per turn
  localparam int unsigned CONTIG_WIDTH = 8;

  // ==============================
  // fifo geometry
  // ==============================

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
  // occupancy needs one more state than the pointers
  localparam int unsigned FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
  localparam logic [FIFO_PTR_WIDTH-1:0] FIFO_LAST_PTR = FIFO_PTR_WIDTH'(FIFO_DEPTH - 1);
  localparam logic [FIFO_CNT_WIDTH-1:0] FIFO_FULL_CNT = FIFO_CNT_WIDTH'(FIFO_DEPTH);

  // ==============================
  // payload types
  // ==============================

  // one input beat, 36 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
  } stream_beat_t;

  // one output beat tagged with its source stream, 38 bits
  typedef struct packed {
    logic [STREAM_ID_WIDTH-1:0] id;
    logic [DATA_WIDTH-1:0]      data;
    logic [STRB_WIDTH-1:0]      strb;
  } tagged_beat_t;

endpackage
